// File: logic/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// byte address into the data SRAM
`define LSU_ADDR_W 32

// one SRAM word, also the register width
`define LSU_DATA_W 32

// 32 architectural registers
`define LSU_RF_AW 5

// one strobe bit per byte lane
`define LSU_STRB_W (`LSU_DATA_W / 8)

`endif

// File: logic/lsu_op_pkg.sv
package lsu_op_pkg;

    typedef enum logic [3:0] {
        ALU   = 4'd0,  // plain result, no memory access
        LD_B  = 4'd1,
        LD_H  = 4'd2,
        LD_W  = 4'd3,
        LD_BU = 4'd4,
        LD_HU = 4'd5,
        ST_B  = 4'd6,
        ST_H  = 4'd7,
        ST_W  = 4'd8
    } mem_op_e;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } acc_size_e;

    function automatic logic is_load(mem_op_e op);
        return op inside {LD_B, LD_H, LD_W, LD_BU, LD_HU};
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {ST_B, ST_H, ST_W};
    endfunction

    function automatic acc_size_e size_of(mem_op_e op);
        if (op inside {LD_B, LD_BU, ST_B}) return BYTE;
        if (op inside {LD_H, LD_HU, ST_H}) return HALF;
        return WORD;  // ALU falls here too, size is ignored then
    endfunction

    function automatic logic is_unsigned(mem_op_e op);
        return op inside {LD_BU, LD_HU};
    endfunction

endpackage

// File: logic/lsu_bus_pkg.sv
`include "lsu_cfg.svh"

package lsu_bus_pkg;
    import lsu_op_pkg::*;

    // one operation as it leaves issue
    typedef struct packed {
        mem_op_e                op;
        logic [`LSU_ADDR_W-1:0] pc;
        logic [`LSU_ADDR_W-1:0] base;
        logic [`LSU_ADDR_W-1:0] offset;
        logic [`LSU_DATA_W-1:0] data;    // store data or ALU value
        logic [`LSU_RF_AW-1:0]  rd;
        logic                   rf_we;
    } issue_t;

    typedef struct packed {
        mem_op_e                op;
        logic [`LSU_ADDR_W-1:0] pc;
        logic [1:0]             addr_lo;  // lane select for the load
        logic [`LSU_RF_AW-1:0]  rd;
        logic                   rf_we;
        logic [`LSU_DATA_W-1:0] alu_val;
        logic                   ale;
        logic                   req_sent; // a data_ok is owed to this item
    } ex_mem_t;

    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] pc;
        logic [`LSU_RF_AW-1:0]  rd;
        logic                   rf_we;
        logic [`LSU_DATA_W-1:0] wdata;
        logic                   ale;
    } mem_wb_t;

endpackage

// File: logic/pipe_slot.sv
module pipe_slot #(
    parameter type payload_t = logic,
    parameter bit  FLUSHABLE = 1'b1
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     allowin,
    input  logic     ready_go,
    input  logic     next_allowin,
    output logic     valid,
    output payload_t payload,
    output logic     fire
);

    // empty, or the current item moves on this cycle
    assign allowin = ~valid | (ready_go & next_allowin);
    assign fire    = in_valid & allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (FLUSHABLE && flush) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;  // drops to 0 when nothing arrives
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            payload <= in_payload;
        end
    end

endmodule

// File: logic/ex_stage.sv
`include "lsu_cfg.svh"

module ex_stage
    import lsu_op_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   flush,
    input  logic                   in_valid,
    output logic                   in_allowin,
    input  mem_op_e                in_op,
    input  logic [`LSU_ADDR_W-1:0] in_pc,
    input  logic [`LSU_ADDR_W-1:0] in_base,
    input  logic [`LSU_ADDR_W-1:0] in_offset,
    input  logic [`LSU_DATA_W-1:0] in_data,
    input  logic [`LSU_RF_AW-1:0]  in_rd,
    input  logic                   in_rf_we,
    input  logic                   mem_allowin,
    output logic                   ex_valid,
    output ex_mem_t                ex_payload,
    output logic                   data_sram_req,
    output logic                   data_sram_wr,
    output logic [`LSU_STRB_W-1:0] data_sram_wstrb,
    output logic [`LSU_ADDR_W-1:0] data_sram_addr,
    output logic [`LSU_DATA_W-1:0] data_sram_wdata
);

    issue_t                 in_item;
    issue_t                 cur;
    logic                   slot_valid;
    logic                   is_mem;
    logic                   misalign;
    logic                   ale;
    logic                   need_req;
    acc_size_e              size;
    logic [`LSU_ADDR_W-1:0] addr;
    logic [`LSU_STRB_W-1:0] strb;

    assign in_item = '{op: in_op, pc: in_pc, base: in_base, offset: in_offset,
                       data: in_data, rd: in_rd, rf_we: in_rf_we};

    // request goes out in the cycle it is raised, so EX never stalls on its own
    pipe_slot #(.payload_t(issue_t), .FLUSHABLE(1'b1)) u_slot (
        .clk(clk), .resetn(resetn), .flush(flush),
        .in_valid(in_valid), .in_payload(in_item), .allowin(in_allowin),
        .ready_go(1'b1), .next_allowin(mem_allowin),
        .valid(slot_valid), .payload(cur), .fire()
    );

    assign addr   = cur.base + cur.offset;
    assign size   = size_of(cur.op);
    assign is_mem = is_load(cur.op) | is_store(cur.op);

    always_comb begin
        case (size)
            HALF:    misalign = addr[0];
            WORD:    misalign = addr[1:0] != 2'b00;
            default: misalign = 1'b0;
        endcase
        case (size)
            BYTE:    strb = `LSU_STRB_W'(4'b0001 << addr[1:0]);
            HALF:    strb = addr[1] ? 4'b1100 : 4'b0011;
            default: strb = 4'b1111;
        endcase
    end

    assign ale      = is_mem & misalign;
    assign need_req = slot_valid & is_mem & ~ale;  // ALE items never touch the SRAM

    assign data_sram_req   = need_req & mem_allowin & ~flush;
    assign data_sram_wr    = is_store(cur.op);
    assign data_sram_wstrb = is_store(cur.op) ? strb : '0;
    assign data_sram_addr  = addr;
    assign data_sram_wdata = (size == BYTE) ? {4{cur.data[7:0]}}  :
                             (size == HALF) ? {2{cur.data[15:0]}} :
                                              cur.data;

    assign ex_valid   = slot_valid;
    assign ex_payload = '{op: cur.op, pc: cur.pc, addr_lo: addr[1:0], rd: cur.rd,
                          rf_we: cur.rf_we, alu_val: cur.data, ale: ale,
                          req_sent: need_req};

endmodule

// File: logic/mem_stage.sv
`include "lsu_cfg.svh"

module mem_stage
    import lsu_op_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   flush,
    input  logic                   ex_valid,
    input  ex_mem_t                ex_payload,
    output logic                   mem_allowin,
    input  logic                   data_sram_data_ok,
    input  logic [`LSU_DATA_W-1:0] data_sram_rdata,
    input  logic                   wb_allowin,
    output logic                   mem_valid,
    output mem_wb_t                mem_payload
);

    ex_mem_t                cur;
    logic                   slot_valid;
    logic                   slot_allowin;
    logic                   ready_go;
    logic                   block;
    logic                   waiting;
    logic                   discard_pending;
    logic                   own_ok;
    logic                   swallow;
    logic                   orphan;
    logic [1:0]             discard_cnt;   // responses still owed to flushed items
    logic [7:0]             byte_val;
    logic [15:0]            half_val;
    logic [`LSU_DATA_W-1:0] load_val;

    assign discard_pending = discard_cnt != 2'd0;
    // responses come back in order, so the old ones are always first
    assign swallow = data_sram_data_ok & discard_pending;
    assign own_ok  = data_sram_data_ok & ~discard_pending;

    assign waiting  = slot_valid & cur.req_sent;
    assign ready_go = ~waiting | own_ok;
    assign orphan   = flush & waiting & ~own_ok;

    // hold off a new request until the stale ones have drained
    assign block       = discard_pending & ex_valid & ex_payload.req_sent;
    assign mem_allowin = slot_allowin & ~block;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            discard_cnt <= 2'd0;
        end else begin
            discard_cnt <= discard_cnt + {1'b0, orphan} - {1'b0, swallow};
        end
    end

    pipe_slot #(.payload_t(ex_mem_t), .FLUSHABLE(1'b1)) u_slot (
        .clk(clk), .resetn(resetn), .flush(flush),
        .in_valid(ex_valid & ~block), .in_payload(ex_payload), .allowin(slot_allowin),
        .ready_go(ready_go), .next_allowin(wb_allowin),
        .valid(slot_valid), .payload(cur), .fire()
    );

    always_comb begin
        case (cur.addr_lo)
            2'd0:    byte_val = data_sram_rdata[7:0];
            2'd1:    byte_val = data_sram_rdata[15:8];
            2'd2:    byte_val = data_sram_rdata[23:16];
            default: byte_val = data_sram_rdata[31:24];
        endcase
        half_val = cur.addr_lo[1] ? data_sram_rdata[31:16] : data_sram_rdata[15:0];
        case (size_of(cur.op))
            BYTE: load_val = {{(`LSU_DATA_W-8){~is_unsigned(cur.op) & byte_val[7]}}, byte_val};
            HALF: load_val = {{(`LSU_DATA_W-16){~is_unsigned(cur.op) & half_val[15]}}, half_val};
            default: load_val = data_sram_rdata;
        endcase
    end

    assign mem_valid = slot_valid & ready_go & ~flush;  // a flushed item never reaches WB

    always_comb begin
        mem_payload.pc    = cur.pc;
        mem_payload.rd    = cur.rd;
        mem_payload.rf_we = cur.rf_we;
        mem_payload.ale   = cur.ale;
        if (is_load(cur.op)) begin
            mem_payload.wdata = load_val;
        end else if (is_store(cur.op)) begin
            mem_payload.wdata = '0;  // stores write nothing back
        end else begin
            mem_payload.wdata = cur.alu_val;
        end
    end

endmodule

// File: logic/wb_stage.sv
`include "lsu_cfg.svh"

module wb_stage
    import lsu_op_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   mem_valid,
    input  mem_wb_t                mem_payload,
    output logic                   wb_allowin,
    output logic                   rf_we,
    output logic [`LSU_RF_AW-1:0]  rf_waddr,
    output logic [`LSU_DATA_W-1:0] rf_wdata,
    output logic                   commit_valid,
    output logic [`LSU_ADDR_W-1:0] commit_pc,
    output logic                   commit_ale
);

    mem_wb_t cur;
    logic    slot_valid;

    // items here are past the point of no return, flush leaves them alone
    pipe_slot #(.payload_t(mem_wb_t), .FLUSHABLE(1'b0)) u_slot (
        .clk(clk), .resetn(resetn), .flush(1'b0),
        .in_valid(mem_valid), .in_payload(mem_payload), .allowin(wb_allowin),
        .ready_go(1'b1), .next_allowin(1'b1),
        .valid(slot_valid), .payload(cur), .fire()
    );

    assign rf_we    = slot_valid & cur.rf_we & ~cur.ale & (cur.rd != '0);  // r0 stays zero
    assign rf_waddr = cur.rd;
    assign rf_wdata = cur.wdata;

    assign commit_valid = slot_valid;
    assign commit_pc    = cur.pc;
    assign commit_ale   = slot_valid & cur.ale;

endmodule

// File: logic/lsu_pipe_top.sv
`include "lsu_cfg.svh"

module lsu_pipe_top
    import lsu_op_pkg::*;
    import lsu_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   flush,
    input  logic                   in_valid,
    output logic                   in_allowin,
    input  mem_op_e                in_op,
    input  logic [`LSU_ADDR_W-1:0] in_pc,
    input  logic [`LSU_ADDR_W-1:0] in_base,
    input  logic [`LSU_ADDR_W-1:0] in_offset,
    input  logic [`LSU_DATA_W-1:0] in_data,
    input  logic [`LSU_RF_AW-1:0]  in_rd,
    input  logic                   in_rf_we,
    output logic                   data_sram_req,
    output logic                   data_sram_wr,
    output logic [`LSU_STRB_W-1:0] data_sram_wstrb,
    output logic [`LSU_ADDR_W-1:0] data_sram_addr,
    output logic [`LSU_DATA_W-1:0] data_sram_wdata,
    input  logic                   data_sram_data_ok,
    input  logic [`LSU_DATA_W-1:0] data_sram_rdata,
    output logic                   rf_we,
    output logic [`LSU_RF_AW-1:0]  rf_waddr,
    output logic [`LSU_DATA_W-1:0] rf_wdata,
    output logic                   commit_valid,
    output logic [`LSU_ADDR_W-1:0] commit_pc,
    output logic                   commit_ale
);

    logic    ex_valid;
    logic    mem_allowin;
    logic    mem_valid;
    logic    wb_allowin;
    ex_mem_t ex_payload;
    mem_wb_t mem_payload;

    ex_stage u_ex (.*);

    mem_stage u_mem (.*);

    wb_stage u_wb (.*);

endmodule

// File: sim/data_sram_model.sv
module data_sram_model (
    input  logic        clk,
    input  logic        resetn,
    input  int          lat_min,  // shortest response delay in cycles, 1 to 4
    input  logic        req,
    input  logic        wr,
    input  logic [3:0]  wstrb,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    output logic        data_ok,
    output logic [31:0] rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [0:255];
    logic [31:0] resp_data [$];
    int          resp_due [$];
    int          cycle;
    int          due;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h9e37_79b9 * (i + 1);  // every word distinct
        end
    end

    always @(posedge clk) begin
        data_ok <= 1'b0;
        if (!resetn) begin
            cycle = 0;
            resp_data.delete();
            resp_due.delete();
        end else begin
            cycle = cycle + 1;
            if (req) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr && wstrb[b]) begin
                        mem[addr[9:2]][8 * b +: 8] = wdata[8 * b +: 8];
                    end
                end
                due = cycle + lat_min - 1 + int'($urandom % (5 - lat_min));
                if (resp_due.size() != 0 && due <= resp_due[$]) begin
                    due = resp_due[$] + 1;  // answers stay in request order
                end
                resp_data.push_back(mem[addr[9:2]]);
                resp_due.push_back(due);
            end
            if (resp_due.size() != 0 && resp_due[0] == cycle) begin
                data_ok <= 1'b1;
                rdata   <= resp_data.pop_front();
                void'(resp_due.pop_front());
            end
        end
    end

endmodule

// File: sim/tb_lsu_pipe.sv
`include "lsu_cfg.svh"

module tb_lsu_pipe
    import lsu_op_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 8;
    localparam int N_TESTS         = 6;
    localparam int CYCLES_PER_TEST = 400;

    typedef struct {
        logic [`LSU_ADDR_W-1:0] pc;
        logic                   ale;
        logic                   we;   // register write expected
        logic [`LSU_RF_AW-1:0]  rd;
        logic [`LSU_DATA_W-1:0] wdata;
    } commit_t;

    logic                   clk;
    logic                   resetn;
    logic                   flush;
    logic                   in_valid;
    logic                   in_allowin;
    mem_op_e                in_op;
    logic [`LSU_ADDR_W-1:0] in_pc;
    logic [`LSU_ADDR_W-1:0] in_base;
    logic [`LSU_ADDR_W-1:0] in_offset;
    logic [`LSU_DATA_W-1:0] in_data;
    logic [`LSU_RF_AW-1:0]  in_rd;
    logic                   in_rf_we;
    logic                   data_sram_req;
    logic                   data_sram_wr;
    logic [`LSU_STRB_W-1:0] data_sram_wstrb;
    logic [`LSU_ADDR_W-1:0] data_sram_addr;
    logic [`LSU_DATA_W-1:0] data_sram_wdata;
    logic                   data_sram_data_ok;
    logic [`LSU_DATA_W-1:0] data_sram_rdata;
    logic                   rf_we;
    logic [`LSU_RF_AW-1:0]  rf_waddr;
    logic [`LSU_DATA_W-1:0] rf_wdata;
    logic                   commit_valid;
    logic [`LSU_ADDR_W-1:0] commit_pc;
    logic                   commit_ale;
    int                     lat_min;
    int                     errors = 0;
    int                     commits = 0;
    int                     req_count = 0;
    logic [31:0]            pc_next;
    logic [31:0]            ref_mem [0:255];  // what the SRAM should hold
    commit_t                exp_q [$];

    lsu_pipe_top DUT (.*);

    data_sram_model u_sram (
        .clk(clk), .resetn(resetn), .lat_min(lat_min),
        .req(data_sram_req), .wr(data_sram_wr), .wstrb(data_sram_wstrb),
        .addr(data_sram_addr), .wdata(data_sram_wdata),
        .data_ok(data_sram_data_ok), .rdata(data_sram_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", N_TESTS * CYCLES_PER_TEST);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic write_ref(input logic [31:0] addr, input logic [31:0] data, input int nbytes);
        for (int b = 0; b < nbytes; b++) begin
            ref_mem[addr[9:2]][8 * (addr[1:0] + b) +: 8] = data[8 * b +: 8];
        end
    endtask

    // queue the expected commit, then hold the item on the issue port until taken
    task automatic issue(input mem_op_e op, input logic [31:0] base, input logic [31:0] offset,
                         input logic [31:0] data, input logic [4:0] rd);
        commit_t     item;
        logic [31:0] addr;
        logic [31:0] word;
        int          nbytes;
        logic        load;
        logic        store;
        logic        accepted;
        addr  = base + offset;
        load  = op inside {LD_B, LD_H, LD_W, LD_BU, LD_HU};
        store = op inside {ST_B, ST_H, ST_W};
        case (op)
            LD_B, LD_BU, ST_B: nbytes = 1;
            LD_H, LD_HU, ST_H: nbytes = 2;
            default:           nbytes = 4;
        endcase
        item.pc  = pc_next;
        item.ale = (load || store) && (addr % nbytes) != 0;
        item.rd  = rd;
        item.we  = !store && !item.ale && rd != 5'd0;
        word     = ref_mem[addr[9:2]] >> (8 * addr[1:0]);  // addressed lane at bit 0
        case (op)
            LD_B:    item.wdata = {{24{word[7]}}, word[7:0]};
            LD_BU:   item.wdata = {24'd0, word[7:0]};
            LD_H:    item.wdata = {{16{word[15]}}, word[15:0]};
            LD_HU:   item.wdata = {16'd0, word[15:0]};
            LD_W:    item.wdata = word;
            default: item.wdata = data;
        endcase
        if (store && !item.ale) begin
            write_ref(addr, data, nbytes);
        end
        exp_q.push_back(item);
        pc_next   = pc_next + 32'd4;
        in_valid  = 1'b1;
        in_op     = op;
        in_pc     = item.pc;
        in_base   = base;
        in_offset = offset;
        in_data   = data;
        in_rd     = rd;
        in_rf_we  = !store;
        accepted  = 1'b0;
        while (!accepted) begin
            accepted = in_allowin;
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(input string name);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected commits never arrived", name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (6) @(posedge clk);  // room for any stray commit to show up
        #1;
    endtask

    task automatic word_store_then_load();
        logic [31:0] addr;
        for (int i = 0; i < 8; i++) begin
            addr = ($urandom % 256) * 4;
            issue(ST_W, addr - 32'd20, 32'd20, $urandom, 5'd0);
            issue(LD_W, addr, 32'd0, 32'd0, 5'(i + 1));
        end
        wait_drain("word store then load");
    endtask

    task automatic sub_word_loads();
        logic [31:0] pattern [2];
        logic [31:0] addr;
        pattern = '{32'h7f80_8001, 32'h8a7f_f601};  // both signs in bytes and halves
        for (int w = 0; w < 2; w++) begin
            addr = 32'h100 + 4 * w;
            issue(ST_W, addr, 32'd0, pattern[w], 5'd0);
            for (int off = 0; off < 4; off++) begin
                issue(LD_B, addr, off, 32'd0, 5'd3);
                issue(LD_BU, addr, off, 32'd0, 5'd4);
                if (off % 2 == 0) begin
                    issue(LD_H, addr, off, 32'd0, 5'd5);
                    issue(LD_HU, addr, off, 32'd0, 5'd5);
                end
            end
        end
        wait_drain("sub-word loads");
    endtask

    task automatic partial_store_merge();
        logic [31:0] addr;
        addr = 32'h200;
        issue(ST_W, addr, 32'd0, 32'h1122_3344, 5'd0);
        for (int off = 0; off < 4; off++) begin
            issue(ST_B, addr, off, $urandom, 5'd0);
            issue(LD_W, addr, 32'd0, 32'd0, 5'd6);
        end
        for (int off = 0; off < 4; off += 2) begin
            issue(ST_H, addr + off, 32'd0, $urandom, 5'd0);
            issue(LD_W, addr, 32'd0, 32'd0, 5'd7);
        end
        wait_drain("partial stores");
    endtask

    task automatic misaligned_access();
        logic [31:0] addr;
        int          reqs_before;
        addr = 32'h300;
        issue(ST_W, addr, 32'd0, 32'hcafe_f00d, 5'd0);
        wait_drain("misaligned setup");
        reqs_before = req_count;
        issue(LD_H, addr, 32'd1, 32'd0, 5'd8);
        issue(LD_H, addr, 32'd3, 32'd0, 5'd8);
        issue(LD_W, addr, 32'd1, 32'd0, 5'd8);
        issue(LD_W, addr, 32'd2, 32'd0, 5'd8);
        issue(ST_H, addr, 32'd1, 32'hdead_beef, 5'd0);
        issue(ST_W, addr, 32'd3, 32'hdead_beef, 5'd0);
        issue(LD_W, addr, 32'd0, 32'd0, 5'd9);  // only this one reaches the SRAM
        wait_drain("misaligned");
        if (req_count != reqs_before + 1) begin
            report_mismatch($sformatf("%0d SRAM requests in misaligned test, expected 1",
                                      req_count - reqs_before));
        end
    endtask

    task automatic flush_in_flight_loads();
        logic [31:0] addr;
        lat_min = 2;  // first load is still waiting when the flush hits
        for (int i = 0; i < 3; i++) begin
            addr = 32'h340 + 16 * i;
            issue(LD_W, addr, 32'd0, 32'd0, 5'd10);
            issue(LD_H, addr, 32'd2, 32'd0, 5'd11);
            exp_q.delete();  // one in MEM, one in EX, neither may commit
            flush = 1'b1;
            @(posedge clk);
            #1;
            flush = 1'b0;
            issue(ST_W, addr, 32'd4, $urandom, 5'd0);
            issue(LD_W, addr, 32'd4, 32'd0, 5'd12);
            issue(LD_BU, addr, 32'd1, 32'd0, 5'd13);
            wait_drain("flush");
        end
        lat_min = 1;
    endtask

    task automatic mixed_traffic();
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] off;
        for (int i = 0; i < 40; i++) begin
            op   = mem_op_e'(4'($urandom % 9));
            off  = $urandom % 64;
            addr = 32'h380 + ($urandom % 32) * 4;
            case (op)
                LD_B, LD_BU, ST_B: addr = addr + $urandom % 4;
                LD_H, LD_HU, ST_H: addr = addr + ($urandom % 2) * 2;
                default: ;
            endcase
            issue(op, addr - off, off, $urandom, 5'($urandom % 4));  // rd 0 now and then
        end
        wait_drain("mixed traffic");
    endtask

    always @(negedge clk) begin
        commit_t e;
        if (resetn && data_sram_req) begin
            req_count++;
        end
        if (resetn && commit_valid) begin
            commits++;
            if (exp_q.size() == 0) begin
                $display("commit of pc %h at %0t with no operation outstanding", commit_pc, $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (commit_pc != e.pc) begin
                    report_mismatch($sformatf("commit pc %h, expected %h", commit_pc, e.pc));
                end
                if (commit_ale != e.ale) begin
                    report_mismatch($sformatf("pc %h ale %b, expected %b", e.pc, commit_ale, e.ale));
                end
                if (rf_we != e.we) begin
                    report_mismatch($sformatf("pc %h rf_we %b, expected %b", e.pc, rf_we, e.we));
                end
                if (e.we && (rf_waddr != e.rd || rf_wdata != e.wdata)) begin
                    report_mismatch($sformatf("pc %h wrote r%0d=%h, expected r%0d=%h",
                                              e.pc, rf_waddr, rf_wdata, e.rd, e.wdata));
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hcd07_c3b3));
        resetn    = 1'b0;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_op     = ALU;
        in_pc     = '0;
        in_base   = '0;
        in_offset = '0;
        in_data   = '0;
        in_rd     = '0;
        in_rf_we  = 1'b0;
        lat_min   = 1;
        pc_next   = 32'h1c00_0000;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 32'h9e37_79b9 * (i + 1);  // same fill as the SRAM model
        end
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        word_store_then_load();
        sub_word_loads();
        partial_store_merge();
        misaligned_access();
        flush_in_flight_loads();
        mixed_traffic();
        $display("errors %0d, commits %0d, sram requests %0d", errors, commits, req_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/lsu_op_pkg.sv
logic/lsu_bus_pkg.sv
logic/pipe_slot.sv
logic/ex_stage.sv
logic/mem_stage.sv
logic/wb_stage.sv
logic/lsu_pipe_top.sv
sim/data_sram_model.sv
sim/tb_lsu_pipe.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps
TOP       = tb_lsu_pipe
FILELIST  = list.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard logic/*.sv logic/*.svh sim/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
